//--- Makefile
# Verilator simulation of the core peripheral group

TOP = tb_core_peri_group

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)

# Fails unless the pass message shows up in the output
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- files.f
logic/peri_bus_pkg.sv
logic/peri_timer_pkg.sv
logic/apb_slot_decoder.sv
logic/timer_ctrl.sv
logic/tick_counter.sv
logic/lock_monitor.sv
logic/core_peri_group.sv
sim/tb_core_peri_group.sv

//--- logic/apb_slot_decoder.sv
// APB slot decoder
// Fans one transfer out to the mapped slots with per-slot sel
// Merges the selected response and answers unmapped slots with an error

`timescale 1ns/1ps

module apb_slot_decoder import peri_bus_pkg::*;
(
	input apb_req_t req,
	output apb_rsp_t rsp,
	output apb_req_t slot_req [NUM_SLOT],
	input apb_rsp_t slot_rsp [NUM_SLOT]
);

	peri_slot_t slot;
	logic [NUM_SLOT-1:0] hit;

	assign slot = peri_slot_t'(req.addr[SLOT_LSB +: SLOT_W]);

	// ************************************************************
	// Request fan-out
	// ************************************************************

	genvar i;
	generate
		for (i = 0; i < NUM_SLOT; i++)
		begin : g_slot
			assign hit[i] = (slot == peri_slot_t'(i));

			always_comb
			begin
				slot_req[i] = req;
				// Only the addressed slot sees sel
				slot_req[i].sel = req.sel && hit[i];
			end
		end
	endgenerate

	// ************************************************************
	// Response merge
	// ************************************************************

	always_comb
	begin
		// Unmapped slot completes at once with an error
		rsp.rdata = '0;
		rsp.ready = 1'b1;
		rsp.slverr = 1'b1;
		for (int k = 0; k < NUM_SLOT; k++)
		begin
			if (hit[k])
				rsp = slot_rsp[k];
		end
	end

	// Master must never raise enable outside a selected transfer
	always_comb
	begin
		if (req.enable)
			assert (req.sel)
			else $error("APB enable high without sel");
	end

endmodule

//--- logic/core_peri_group.sv
// Core-local peripheral group
// APB slot decoder with timer, lock monitor and external cache-control port
// Core interrupt vector built from the timer and PLIC lines

`timescale 1ns/1ps

module core_peri_group import peri_bus_pkg::*;
#(
	parameter int BW_COUNT = 16,
	parameter int NUM_LOCK = 8
)
(
	input logic clk,
	input logic rstnn,
	input apb_req_t req,
	output apb_rsp_t rsp,
	input logic tick_1us,
	input logic plic_interrupt,
	input logic [NUM_LOCK-1:0] lock_status,
	input logic allows_holds,
	output logic [IRQ_W-1:0] core_interrupt_vector,
	output apb_req_t ext_req,
	input apb_rsp_t ext_rsp
);

	apb_req_t slot_req [NUM_SLOT];
	apb_rsp_t slot_rsp [NUM_SLOT];

	logic [BW_COUNT-1:0] count;
	logic [BW_COUNT-1:0] limit;
	logic expire;
	logic run;
	logic clear_count;
	logic timer_irq;

	apb_slot_decoder i_decoder
	(
		.req(req),
		.rsp(rsp),
		.slot_req(slot_req),
		.slot_rsp(slot_rsp)
	);

	// ************************************************************
	// Slot 0 timer
	// ************************************************************

	timer_ctrl #(.BW_COUNT(BW_COUNT)) i_timer_ctrl
	(
		.clk(clk),
		.rstnn(rstnn),
		.req(slot_req[int'(SLOT_TIMER)]),
		.rsp(slot_rsp[int'(SLOT_TIMER)]),
		.count(count),
		.expire(expire),
		.run(run),
		.clear_count(clear_count),
		.limit(limit),
		.timer_irq(timer_irq)
	);

	tick_counter #(.BW_COUNT(BW_COUNT)) i_tick_counter
	(
		.clk(clk),
		.rstnn(rstnn),
		.tick_1us(tick_1us),
		.run(run),
		.clear_count(clear_count),
		.limit(limit),
		.count(count),
		.expire(expire)
	);

	// Slot 1 lock monitor
	lock_monitor #(.NUM_LOCK(NUM_LOCK)) i_lock_monitor
	(
		.clk(clk),
		.rstnn(rstnn),
		.req(slot_req[int'(SLOT_LOCK)]),
		.rsp(slot_rsp[int'(SLOT_LOCK)]),
		.lock_status(lock_status),
		.allows_holds(allows_holds)
	);

	// Slot 2 leaves the group unchanged
	assign ext_req = slot_req[int'(SLOT_EXT)];
	assign slot_rsp[int'(SLOT_EXT)] = ext_rsp;

	always_comb
	begin
		core_interrupt_vector = '0;
		core_interrupt_vector[IRQ_BIT_TIMER] = timer_irq;
		core_interrupt_vector[IRQ_BIT_EXT] = plic_interrupt;
	end

endmodule

//--- logic/lock_monitor.sv
// Hardware lock monitor
// Two-flop synchronizer on the lock status bus
// Busy query against the address mask, with optional bus hold

`timescale 1ns/1ps

module lock_monitor import peri_bus_pkg::*;
#(
	parameter int NUM_LOCK = 8
)
(
	input logic clk,
	input logic rstnn,
	input apb_req_t req,
	output apb_rsp_t rsp,
	input logic [NUM_LOCK-1:0] lock_status,
	input logic allows_holds
);

	logic [NUM_LOCK-1:0] status_meta;
	logic [NUM_LOCK-1:0] status_sync;
	logic [LOCK_MASK_W-1:0] mask_field;
	logic [NUM_LOCK-1:0] mask;
	logic busy;

	// ************************************************************
	// Synchronizer
	// ************************************************************

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			status_meta <= '0;
			status_sync <= '0;
		end
		else
		begin
			status_meta <= lock_status;
			status_sync <= status_meta;
		end
	end

	// ************************************************************
	// Busy query
	// ************************************************************

	assign mask_field = req.addr[LOCK_MASK_LSB +: LOCK_MASK_W];
	assign mask = mask_field[NUM_LOCK-1:0];
	assign busy = |(mask & status_sync);

	always_comb
	begin
		rsp.rdata = DATA_W'(busy);
		// Hold the core until the lock frees
		rsp.ready = allows_holds ? !busy : 1'b1;
		rsp.slverr = 1'b0;
	end

	// A held transfer keeps its address and stays selected
	a_hold_stable: assert property (@(posedge clk) disable iff (!rstnn)
		(req.sel && req.enable && !rsp.ready) |=> (req.sel && $stable(req.addr)))
		else $error("request changed while the lock slot held the bus");

endmodule

//--- logic/peri_bus_pkg.sv
// APB request and response structs for the peripheral group
// Slot enum taken from the upper address bits
// Address-map constants, bus widths and interrupt vector bit positions

package peri_bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Slot index lives in address bits 15 to 12
	localparam int SLOT_W = 4;
	localparam int SLOT_LSB = 12;
	localparam int NUM_SLOT = 3;

	// Lock query mask in address bits 9 to 2
	localparam int LOCK_MASK_LSB = 2;
	localparam int LOCK_MASK_W = 8;

	localparam int IRQ_W = 32;
	localparam int IRQ_BIT_TIMER = 7;
	localparam int IRQ_BIT_EXT = 11;

	typedef struct packed {
		logic sel;
		logic enable;
		logic [ADDR_W-1:0] addr;
		logic write;
		logic [DATA_W-1:0] wdata;
	} apb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic ready;
		logic slverr;
	} apb_rsp_t;

	// Values 3 to 15 are unmapped
	typedef enum logic [SLOT_W-1:0] {
		SLOT_TIMER = 4'd0,
		SLOT_LOCK = 4'd1,
		SLOT_EXT = 4'd2
	} peri_slot_t;

endpackage

//--- logic/peri_timer_pkg.sv
// Timer FSM state and command opcode enums
// Timer register offsets selected by address bits 3 to 2

package peri_timer_pkg;

	localparam int REG_SEL_LSB = 2;
	localparam int REG_SEL_W = 2;
	localparam int CMD_W = 8;

	typedef enum logic [1:0] {
		TS_IDLE = 2'd0,
		TS_RUN = 2'd1,
		TS_EXPIRED = 2'd2
	} timer_state_t;

	// Any other opcode written to CMD is ignored
	typedef enum logic [CMD_W-1:0] {
		CMD_START = 8'd1,
		CMD_STOP = 8'd2,
		CMD_CLEAR = 8'd3
	} timer_cmd_t;

	localparam logic [REG_SEL_W-1:0] REG_CMD = 2'd0;
	localparam logic [REG_SEL_W-1:0] REG_LIMIT = 2'd1;
	localparam logic [REG_SEL_W-1:0] REG_COUNT = 2'd2;
	localparam logic [REG_SEL_W-1:0] REG_STATUS = 2'd3;

endpackage

//--- logic/tick_counter.sv
// Microsecond tick counter
// Counts tick pulses while running and stops at the programmed limit
// One-cycle expire pulse once the count sits at a nonzero limit

`timescale 1ns/1ps

module tick_counter
#(
	parameter int BW_COUNT = 16
)
(
	input logic clk,
	input logic rstnn,
	input logic tick_1us,
	input logic run,
	input logic clear_count,
	input logic [BW_COUNT-1:0] limit,
	output logic [BW_COUNT-1:0] count,
	output logic expire
);

	logic at_limit;

	// A zero limit never expires
	assign at_limit = (limit != '0) && (count == limit);

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			count <= '0;
			expire <= 1'b0;
		end
		else if (clear_count)
		begin
			count <= '0;
			expire <= 1'b0;
		end
		else
		begin
			if (run && tick_1us && (count < limit))
				count <= count + 1'b1;
			// Pulse once, the cycle after the limit is reached
			expire <= run && at_limit && !expire;
		end
	end

	a_count_le_limit: assert property (@(posedge clk) disable iff (!rstnn)
		run |-> (count <= limit))
		else $error("tick count beyond limit while running");

endmodule

//--- logic/timer_ctrl.sv
// Microsecond timer control
// CMD and LIMIT registers, STATUS and COUNT readback
// FSM over idle, run and expired that drives the interrupt level

`timescale 1ns/1ps

module timer_ctrl import peri_bus_pkg::*, peri_timer_pkg::*;
#(
	parameter int BW_COUNT = 16
)
(
	input logic clk,
	input logic rstnn,
	input apb_req_t req,
	output apb_rsp_t rsp,
	input logic [BW_COUNT-1:0] count,
	input logic expire,
	output logic run,
	output logic clear_count,
	output logic [BW_COUNT-1:0] limit,
	output logic timer_irq
);

	logic [REG_SEL_W-1:0] reg_sel;
	logic wr_en;
	logic cmd_wr;
	timer_cmd_t cmd;
	timer_state_t state;
	timer_state_t state_next;
	logic irq_next;

	assign reg_sel = req.addr[REG_SEL_LSB +: REG_SEL_W];
	// Ready is always high, so every access cycle completes
	assign wr_en = req.sel && req.enable && req.write;
	assign cmd_wr = wr_en && (reg_sel == REG_CMD);
	assign cmd = timer_cmd_t'(req.wdata[CMD_W-1:0]);

	// ************************************************************
	// FSM
	// ************************************************************

	always_comb
	begin
		state_next = state;
		irq_next = timer_irq;
		clear_count = 1'b0;

		if (expire && (state == TS_RUN))
		begin
			state_next = TS_EXPIRED;
			irq_next = 1'b1;
		end

		// A command written in the same cycle wins over expiry
		if (cmd_wr)
		begin
			case (cmd)
				CMD_START:
				begin
					state_next = TS_RUN;
					irq_next = 1'b0;
					clear_count = 1'b1;
				end
				CMD_STOP:
				begin
					state_next = TS_IDLE;
					irq_next = 1'b0;
				end
				CMD_CLEAR:
				begin
					state_next = TS_IDLE;
					irq_next = 1'b0;
					clear_count = 1'b1;
				end
				default:
				begin
					// Unknown opcodes leave the FSM alone
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			state <= TS_IDLE;
			timer_irq <= 1'b0;
			limit <= '0;
		end
		else
		begin
			state <= state_next;
			timer_irq <= irq_next;
			if (wr_en && (reg_sel == REG_LIMIT))
				limit <= req.wdata[BW_COUNT-1:0];
		end
	end

	assign run = (state == TS_RUN);

	// ************************************************************
	// Register readback
	// ************************************************************

	always_comb
	begin
		case (reg_sel)
			REG_LIMIT: rsp.rdata = DATA_W'(limit);
			REG_COUNT: rsp.rdata = DATA_W'(count);
			REG_STATUS: rsp.rdata = DATA_W'(state);
			// CMD is write only
			default: rsp.rdata = '0;
		endcase
		rsp.ready = 1'b1;
		rsp.slverr = 1'b0;
	end

	a_irq_only_expired: assert property (@(posedge clk) disable iff (!rstnn)
		timer_irq |-> (state == TS_EXPIRED))
		else $error("timer_irq high outside TS_EXPIRED");

endmodule

//--- sim/peri_golden.txt
# Columns in hex: op addr data expected slverr
# op 0 end of test (data = test number), 1 write, 2 read, 3 set lock (data = status),
# 4 tick burst (data = pulses), 5 wait for vector (data = max cycles), 6 plic and holds
# (data bit 0 plic, bit 1 holds), 7 held read (data = cycles until the lock frees)
2 00005000 00000000 00000000 1
2 0000f004 00000000 00000000 1
2 00002010 00000000 00002011 0
2 00002abc 00000000 00002abd 0
1 00002008 12345678 00000000 0
0 00000000 00000001 00000000 0
2 0000000c 00000000 00000000 0
1 00000004 00000005 00000000 0
2 00000004 00000000 00000005 0
1 00000000 00000001 00000000 0
2 0000000c 00000000 00000001 0
0 00000000 00000002 00000000 0
4 00000000 00000005 00000000 0
5 00000000 00000002 00000080 0
2 00000008 00000000 00000005 0
2 0000000c 00000000 00000002 0
1 00000000 00000003 00000000 0
5 00000000 00000001 00000000 0
2 0000000c 00000000 00000000 0
0 00000000 00000003 00000000 0
6 00000000 00000001 00000000 0
5 00000000 00000001 00000800 0
6 00000000 00000000 00000000 0
5 00000000 00000001 00000000 0
0 00000000 00000004 00000000 0
3 00000000 00000001 00000000 0
2 00001004 00000000 00000001 0
2 00001030 00000000 00000000 0
3 00000000 00000008 00000000 0
2 00001030 00000000 00000001 0
2 000013c0 00000000 00000000 0
0 00000000 00000005 00000000 0
6 00000000 00000002 00000000 0
3 00000000 00000010 00000000 0
7 00001040 00000004 00000000 0
6 00000000 00000000 00000000 0
0 00000000 00000006 00000000 0

//--- sim/tb_core_peri_group.sv
// Testbench for the core-local peripheral group
// Replays operations from a data file through an APB master task
// Models the external cache-control slot and keeps a watchdog

`timescale 1ns/1ps

module tb_core_peri_group import peri_bus_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int BW_COUNT = 16;
	localparam int NUM_LOCK = 8;
	localparam int XFER_LIMIT = 100;

	logic clk;
	logic rstnn;
	apb_req_t req;
	apb_rsp_t rsp;
	logic tick_1us;
	logic plic_interrupt;
	logic [NUM_LOCK-1:0] lock_status;
	logic allows_holds;
	logic [IRQ_W-1:0] core_interrupt_vector;
	apb_req_t ext_req;
	apb_rsp_t ext_rsp;

	integer seed = 32'hfd58_49ba;
	int error_count = 0;
	int pass_count = 0;
	int test_errors = 0;
	int num_ops = 0;

	// One entry per operation line
	logic [31:0] op_q [$];
	logic [31:0] addr_q [$];
	logic [31:0] data_q [$];
	logic [31:0] exp_q [$];
	logic [31:0] err_q [$];

	core_peri_group #(.BW_COUNT(BW_COUNT), .NUM_LOCK(NUM_LOCK)) uut
	(
		.clk(clk),
		.rstnn(rstnn),
		.req(req),
		.rsp(rsp),
		.tick_1us(tick_1us),
		.plic_interrupt(plic_interrupt),
		.lock_status(lock_status),
		.allows_holds(allows_holds),
		.core_interrupt_vector(core_interrupt_vector),
		.ext_req(ext_req),
		.ext_rsp(ext_rsp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ************************************************************
	// Helper tasks
	// ************************************************************

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
				$time, msg, actual, expected);
			error_count++;
			test_errors++;
		end
		else
			pass_count++;
	endtask

	task automatic read_operations;
		int fd;
		int n;
		string line;
		logic [31:0] f_op;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [31:0] f_exp;
		logic [31:0] f_err;
		fd = $fopen("sim/peri_golden.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the operation file sim/peri_golden.txt");
			error_count++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() == 0 || line[0] == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_data, f_exp, f_err);
			if (n == 5)
			begin
				op_q.push_back(f_op);
				addr_q.push_back(f_addr);
				data_q.push_back(f_data);
				exp_q.push_back(f_exp);
				err_q.push_back(f_err);
			end
		end
		$fclose(fd);
		num_ops = op_q.size();
	endtask

	// Starts and ends 2 ns after a rising edge, bus idle on return
	task automatic apb_transfer(input logic wr, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
		output logic done);
		int cycles;
		req.sel = 1'b1;
		req.enable = 1'b0;
		req.addr = addr;
		req.write = wr;
		req.wdata = wdata;
		@(posedge clk);
		#2;
		req.enable = 1'b1;
		cycles = 0;
		done = 1'b0;
		rdata = '0;
		err = 1'b0;
		while (!done && cycles < XFER_LIMIT)
		begin
			// Sample mid-cycle, away from the register updates
			@(negedge clk);
			if (rsp.ready)
			begin
				rdata = rsp.rdata;
				err = rsp.slverr;
				done = 1'b1;
			end
			@(posedge clk);
			cycles++;
		end
		#2;
		req = '0;
		if (!done)
		begin
			$display("APB transfer to address %h never completed", addr);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic pulse_ticks(input int pulses);
		repeat (pulses)
		begin
			tick_1us = 1'b1;
			@(posedge clk);
			#2;
			tick_1us = 1'b0;
			@(posedge clk);
			#2;
		end
	endtask

	// Looks at the vector once per cycle, at most max_cycles times
	task automatic wait_vector(input logic [31:0] expected, input int max_cycles);
		int waited;
		logic [31:0] seen;
		waited = 0;
		forever
		begin
			@(negedge clk);
			seen = core_interrupt_vector;
			waited++;
			if (seen == expected || waited >= max_cycles)
				break;
		end
		check_value(seen, expected, "interrupt vector");
		@(posedge clk);
		#2;
	endtask

	task automatic set_lock(input logic [NUM_LOCK-1:0] value);
		lock_status = value;
		// Leave room for the 2-flop synchronizer
		repeat (3) @(posedge clk);
		#2;
	endtask

	task automatic held_read(input logic [31:0] addr, input int release_cycles,
		input logic [31:0] expected, input logic exp_err);
		logic [31:0] rdata;
		logic err;
		logic done;
		time release_time;
		time finish_time;
		release_time = 0;
		finish_time = 0;
		fork
			begin
				apb_transfer(1'b0, addr, '0, rdata, err, done);
				finish_time = $time;
			end
			begin
				repeat (release_cycles) @(posedge clk);
				#2;
				lock_status = '0;
				release_time = $time;
			end
		join
		check_value(32'(done && (finish_time > release_time)), 1,
			"held read completed after lock release");
		if (done)
		begin
			check_value(rdata, expected, "held read data");
			check_value(32'(err), 32'(exp_err), "held read slverr");
		end
	endtask

	task automatic run_operation(input int i);
		logic [31:0] rdata;
		logic err;
		logic done;
		case (op_q[i])
			0:
			begin
				$display("Test %0d finished with %0d errors", data_q[i], test_errors);
				test_errors = 0;
			end
			1:
			begin
				apb_transfer(1'b1, addr_q[i], data_q[i], rdata, err, done);
				if (done)
					check_value(32'(err), err_q[i], "write slverr");
			end
			2:
			begin
				apb_transfer(1'b0, addr_q[i], '0, rdata, err, done);
				if (done)
				begin
					check_value(rdata, exp_q[i], "read data");
					check_value(32'(err), err_q[i], "read slverr");
				end
			end
			3: set_lock(data_q[i][NUM_LOCK-1:0]);
			4: pulse_ticks(int'(data_q[i]));
			5: wait_vector(exp_q[i], int'(data_q[i]));
			6:
			begin
				plic_interrupt = data_q[i][0];
				allows_holds = data_q[i][1];
			end
			7: held_read(addr_q[i], int'(data_q[i]), exp_q[i], err_q[i][0]);
			default:
			begin
				$display("Unknown operation code %h on operation %0d", op_q[i], i);
				error_count++;
				test_errors++;
			end
		endcase
	endtask

	// ************************************************************
	// External slot responder, returns address plus one
	// ************************************************************

	initial
	begin : ext_responder
		int wait_cycles;
		ext_rsp = '0;
		forever
		begin
			@(posedge clk);
			// Only a transfer to slot 2 may reach the external port
			if (req.sel && !req.enable)
				check_value(32'(ext_req.sel), 32'(req.addr[15:12] == 4'd2), "external sel");
			if (ext_req.sel && !ext_req.enable)
			begin
				check_value(32'(ext_req.write), 32'(req.write), "external write strobe");
				check_value(ext_req.wdata, req.wdata, "external write data");
				wait_cycles = $random(seed) & 3;
				repeat (wait_cycles) @(posedge clk);
				#2;
				ext_rsp.rdata = ext_req.addr + 1;
				ext_rsp.ready = 1'b1;
				ext_rsp.slverr = 1'b0;
				@(posedge clk);
				#2;
				ext_rsp = '0;
			end
		end
	end

	// ************************************************************
	// Main sequence and watchdog
	// ************************************************************

	initial
	begin
		clk = 1'b0;
		rstnn = 1'b0;
		req = '0;
		tick_1us = 1'b0;
		plic_interrupt = 1'b0;
		lock_status = '0;
		allows_holds = 1'b0;
		read_operations();
		repeat (3) @(posedge clk);
		#2;
		rstnn = 1'b1;
		@(posedge clk);
		#2;
		for (int i = 0; i < num_ops; i++)
			run_operation(i);
		$display("Checks passed %0d, errors %0d", pass_count, error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial
	begin
		wait (num_ops > 0);
		repeat (num_ops * 200) @(posedge clk);
		$display("Timeout, the run did not finish within %0d cycles", num_ops * 200);
		$display("Errors found");
		$finish;
	end

endmodule
